// File: hdl/isaPkg.sv
package isaPkg;

	localparam int dataWidth = 16; // one machine word

	typedef logic [dataWidth-1:0] word_t;

	typedef enum logic [1:0] {
		selAx,
		selBx,
		selCx,
		selDx
	} regSel_t;

	// register fields sit in par1 with dst in [3:2] and src in [1:0]
	// immediates and data addresses sit in par2, jump targets in par1
	localparam word_t opNop   = 16'h0000;
	localparam word_t opMov   = 16'h0007; // dst <= src
	localparam word_t opMovi  = 16'h0008; // dst <= par2
	localparam word_t opStore = 16'h002A; // mem[par2] <= src
	localparam word_t opLoad  = 16'h002B; // dst <= mem[par2]
	localparam word_t opOut   = 16'h000A; // bus[bx] <= dx
	localparam word_t opIn    = 16'h0028; // dx <= bus[bx]
	localparam word_t opAdd   = 16'h000C;
	localparam word_t opAdc   = 16'h000D;
	localparam word_t opSub   = 16'h000E;
	localparam word_t opSuc   = 16'h000F; // subtract with borrow
	localparam word_t opMul8  = 16'h0010;
	localparam word_t opCmp   = 16'h0014;
	localparam word_t opAnd   = 16'h0015;
	localparam word_t opNeg   = 16'h0016; // bitwise invert of dst
	localparam word_t opOr    = 16'h0018;
	localparam word_t opXor   = 16'h0019;
	localparam word_t opShl   = 16'h001A;
	localparam word_t opShr   = 16'h001B;
	localparam word_t opJmp   = 16'h0031;
	localparam word_t opJc    = 16'h0021;
	localparam word_t opJnc   = 16'h0022;
	localparam word_t opJz    = 16'h0023;
	localparam word_t opJnz   = 16'h0024;

	localparam logic [1:0] lenOne   = 2'd1;
	localparam logic [1:0] lenTwo   = 2'd2;
	localparam logic [1:0] lenThree = 2'd3;

	typedef enum logic [1:0] {
		busIdle = 2'b00,
		busRd   = 2'b01,
		busWr   = 2'b10
	} busCode_t;

	localparam word_t haltAddr = 16'hFFFF; // end marker address of a test program

	// unknown opcodes fall through as one-word nops
	function automatic logic [1:0] insnLen(word_t op);
		case (op)
			opMovi, opStore, opLoad: return lenThree;
			opMov, opAdd, opAdc, opSub, opSuc, opMul8, opCmp,
			opAnd, opNeg, opOr, opShl, opShr, opXor,
			opJmp, opJc, opJnc, opJz, opJnz: return lenTwo;
			opNop, opOut, opIn: return lenOne;
			default: return lenOne;
		endcase
	endfunction

endpackage

// File: hdl/aluPkg.sv
package aluPkg;

	typedef enum logic [3:0] {
		aluAdd,
		aluAdc,
		aluSub,
		aluSuc, // a - b - carry
		aluMul8, // low bytes only
		aluCmp, // sub with the result dropped
		aluAnd,
		aluInv,
		aluOr,
		aluXor,
		aluShl,
		aluShr
	} aluOp_t;

	typedef struct packed {
		logic carry;
		logic zero;
		logic overflow;
	} flags_t;

	// arithmetic ops own all three flags, the rest only zero
	function automatic logic writesAllFlags(aluOp_t op);
		return op inside {aluAdd, aluAdc, aluSub, aluSuc, aluCmp};
	endfunction

endpackage

// File: hdl/progRam.sv
module progRam #(
	parameter int addrWidth = 12
) (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic [addrWidth-1:0] fetchAddr0,
	input  logic [addrWidth-1:0] fetchAddr1,
	input  logic [addrWidth-1:0] fetchAddr2,
	input  logic [addrWidth-1:0] dataAddr,
	input  logic [addrWidth-1:0] wrAddr,
	input  isaPkg::word_t        wrData,
	input  logic                 wrEn,
	input  logic                 loadEn,
	input  logic [addrWidth-1:0] loadAddr,
	input  isaPkg::word_t        loadData,
	output isaPkg::word_t        fetchWord0,
	output isaPkg::word_t        fetchWord1,
	output isaPkg::word_t        fetchWord2,
	output isaPkg::word_t        dataWord
);
	import isaPkg::*;

	localparam int depth = 2 ** addrWidth;

	word_t mem [depth]; // code and data share one space

	always_ff @(posedge clk) begin
		if (loadEn) begin
			mem[loadAddr] <= loadData; // program load wins
		end else if (wrEn) begin
			mem[wrAddr] <= wrData;
		end
	end

	// opcode, par1 and par2 in one cycle
	assign fetchWord0 = mem[fetchAddr0];
	assign fetchWord1 = mem[fetchAddr1];
	assign fetchWord2 = mem[fetchAddr2];

	assign dataWord = mem[dataAddr]; // absolute load

	// the program goes in only while the core is held in reset
	loadInReset: assert property (@(posedge clk) rstN |-> !loadEn)
		else $error("progRam: loadEn high outside reset");

endmodule

// File: hdl/regFile.sv
module regFile (
	input  logic             clk,
	input  logic             rstN,
	input  isaPkg::regSel_t  rdSelA,
	input  isaPkg::regSel_t  rdSelB,
	input  isaPkg::regSel_t  wrSel,
	input  logic             wrEn,
	input  isaPkg::word_t    wrData,
	output isaPkg::word_t    rdDataA,
	output isaPkg::word_t    rdDataB,
	output isaPkg::word_t    regBx,
	output isaPkg::word_t    regDx
);
	import isaPkg::*;

	word_t regs [4]; // ax, bx, cx, dx

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			regs <= '{default: '0};
		end else if (wrEn) begin
			regs[wrSel] <= wrData;
		end
	end

	assign rdDataA = regs[rdSelA]; // dst operand
	assign rdDataB = regs[rdSelB]; // src operand

	// bus address and write data come straight from bx and dx
	assign regBx = regs[selBx];
	assign regDx = regs[selDx];

endmodule

// File: hdl/alu.sv
module alu (
	input  logic            clk,
	input  logic            rstN,
	input  logic            start,
	input  aluPkg::aluOp_t  op,
	input  isaPkg::word_t   a,
	input  isaPkg::word_t   b,
	input  logic            carryIn,
	output isaPkg::word_t   result,
	output aluPkg::flags_t  flagsOut
);
	import isaPkg::*;
	import aluPkg::*;

	localparam int msb = dataWidth - 1;

	logic [dataWidth:0] sum; // carry out on top
	logic [dataWidth:0] diff; // borrow out on top
	logic               cin;
	word_t              nextResult;
	flags_t             nextFlags;

	assign cin = (op == aluAdc || op == aluSuc) ? carryIn : 1'b0;
	assign sum = {1'b0, a} + {1'b0, b} + {{dataWidth{1'b0}}, cin};
	assign diff = {1'b0, a} - {1'b0, b} - {{dataWidth{1'b0}}, cin};

	always_comb begin
		nextResult = '0;
		nextFlags = '0;
		case (op)
			aluAdd, aluAdc: begin
				nextResult = sum[msb:0];
				nextFlags.carry = sum[dataWidth];
				// same sign in, other sign out
				nextFlags.overflow = (a[msb] == b[msb]) && (nextResult[msb] != a[msb]);
			end
			aluSub, aluSuc, aluCmp: begin
				nextResult = diff[msb:0];
				nextFlags.carry = diff[dataWidth];
				nextFlags.overflow = (a[msb] != b[msb]) && (nextResult[msb] != a[msb]);
			end
			aluMul8: nextResult = {8'h00, a[7:0]} * {8'h00, b[7:0]};
			aluAnd: nextResult = a & b;
			aluInv: nextResult = ~a;
			aluOr: nextResult = a | b;
			aluXor: nextResult = a ^ b;
			aluShl: nextResult = {a[msb-1:0], 1'b0};
			aluShr: nextResult = {1'b0, a[msb:1]};
			default: nextResult = a;
		endcase
		nextFlags.zero = (nextResult == '0);
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			flagsOut <= '0;
		end else if (start) begin
			flagsOut <= nextFlags;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			result <= nextResult;
		end
	end

	// the controller waits out the result cycle before the next op
	noBackToBack: assert property (@(posedge clk) disable iff (!rstN) start |=> !start)
		else $error("alu: start on two consecutive cycles");

endmodule

// File: hdl/cpuControl.sv
module cpuControl #(
	parameter int addrWidth = 12
) (
	input  logic                 clk,
	input  logic                 rstN,
	input  isaPkg::word_t        fetchWord0,
	input  isaPkg::word_t        fetchWord1,
	input  isaPkg::word_t        fetchWord2,
	input  isaPkg::word_t        dataWord,
	input  isaPkg::word_t        rdDataA,
	input  isaPkg::word_t        rdDataB,
	input  isaPkg::word_t        regBx,
	input  isaPkg::word_t        aluResult,
	input  aluPkg::flags_t       aluFlags,
	input  isaPkg::word_t        busRdData,
	output logic [addrWidth-1:0] fetchAddr0,
	output logic [addrWidth-1:0] fetchAddr1,
	output logic [addrWidth-1:0] fetchAddr2,
	output logic [addrWidth-1:0] dataAddr,
	output logic [addrWidth-1:0] wrAddr,
	output isaPkg::word_t        wrData,
	output logic                 wrEn,
	output isaPkg::regSel_t      rdSelA,
	output isaPkg::regSel_t      rdSelB,
	output isaPkg::regSel_t      regWrSel,
	output logic                 regWrEn,
	output isaPkg::word_t        regWrData,
	output logic                 aluStart,
	output aluPkg::aluOp_t       aluOp,
	output isaPkg::word_t        aluA,
	output isaPkg::word_t        aluB,
	output logic                 carryOut,
	output logic                 busWrite,
	output logic                 busRead
);
	import isaPkg::*;
	import aluPkg::*;

	logic [addrWidth-1:0] pc;
	logic [addrWidth-1:0] nextPc;
	flags_t               flags;
	logic                 phase; // second cycle of a two-cycle insn
	logic                 running; // first cycle out of reset is idle
	logic                 twoCycle;
	logic                 useAlu;
	logic                 decWrEn;
	logic                 decRegWrEn;
	logic                 done;
	busCode_t             busCmd;

	assign fetchAddr0 = pc;
	assign fetchAddr1 = pc + 1'b1;
	assign fetchAddr2 = pc + 2'd2;
	assign dataAddr = fetchWord2[addrWidth-1:0];
	assign wrAddr = fetchWord2[addrWidth-1:0];
	assign wrData = rdDataB; // store src
	assign rdSelA = regSel_t'(fetchWord1[3:2]);
	assign rdSelB = regSel_t'(fetchWord1[1:0]);
	assign aluA = rdDataA;
	assign aluB = rdDataB;
	assign carryOut = flags.carry; // for adc and suc

	always_comb begin
		useAlu = 1'b1;
		aluOp = aluAdd;
		case (fetchWord0)
			opAdd: aluOp = aluAdd;
			opAdc: aluOp = aluAdc;
			opSub: aluOp = aluSub;
			opSuc: aluOp = aluSuc;
			opMul8: aluOp = aluMul8;
			opCmp: aluOp = aluCmp;
			opAnd: aluOp = aluAnd;
			opNeg: aluOp = aluInv;
			opOr: aluOp = aluOr;
			opXor: aluOp = aluXor;
			opShl: aluOp = aluShl;
			opShr: aluOp = aluShr;
			default: useAlu = 1'b0;
		endcase
	end

	always_comb begin
		nextPc = pc + addrWidth'(insnLen(fetchWord0));
		twoCycle = useAlu;
		decWrEn = 1'b0;
		decRegWrEn = useAlu & phase & (aluOp != aluCmp); // cmp only sets flags
		regWrSel = rdSelA;
		regWrData = useAlu ? aluResult : rdDataB;
		busCmd = busIdle;
		case (fetchWord0)
			opMov: decRegWrEn = 1'b1;
			opMovi: begin
				decRegWrEn = 1'b1;
				regWrData = fetchWord2;
			end
			opStore: decWrEn = 1'b1;
			opLoad: begin
				twoCycle = 1'b1;
				decRegWrEn = phase;
				regWrData = dataWord;
			end
			opOut: busCmd = busWr;
			opIn: begin
				twoCycle = 1'b1;
				if (!phase) begin
					busCmd = busRd;
				end
				decRegWrEn = phase; // responder data valid now
				regWrSel = selDx;
				regWrData = busRdData;
			end
			opJmp: nextPc = fetchWord1[addrWidth-1:0];
			opJc: if (flags.carry) nextPc = fetchWord1[addrWidth-1:0];
			opJnc: if (!flags.carry) nextPc = fetchWord1[addrWidth-1:0];
			opJz: if (flags.zero) nextPc = fetchWord1[addrWidth-1:0];
			opJnz: if (!flags.zero) nextPc = fetchWord1[addrWidth-1:0];
			default: ;
		endcase
	end

	assign done = !twoCycle || phase;
	assign wrEn = running & decWrEn;
	assign regWrEn = running & decRegWrEn;
	assign aluStart = running & useAlu & ~phase;
	assign busWrite = running & (busCmd == busWr);
	assign busRead = running & (busCmd == busRd);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			running <= 1'b0;
			pc <= '0;
			phase <= 1'b0;
			flags <= '0;
		end else begin
			running <= 1'b1;
			if (running) begin
				phase <= twoCycle & ~phase;
				if (done) begin
					pc <= nextPc;
				end
				if (useAlu && phase) begin
					if (writesAllFlags(aluOp)) begin
						flags <= aluFlags;
					end else begin
						flags.zero <= aluFlags.zero; // mul8 and bitwise
					end
				end
			end
		end
	end

	// an IN read cycle is followed by its capture cycle, bus otherwise quiet
	busExclusive: assert property (@(posedge clk) disable iff (!rstN)
		busRead |-> !busWrite ##1 !(busRead || busWrite))
		else $error("cpuControl: bus strobes overlap");

	// responder answers from bx, which must hold until dx is written
	// (bx == haltAddr on an OUT is the end marker of a test program)
	inAddrStable: assert property (@(posedge clk) disable iff (!rstN)
		busRead |=> $stable(regBx))
		else $error("cpuControl: bx moved during IN");

endmodule

// File: hdl/cpuTop.sv
module cpuTop #(
	parameter int addrWidth = 12
) (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 loadEn,
	input  logic [addrWidth-1:0] loadAddr,
	input  isaPkg::word_t        loadData,
	input  isaPkg::word_t        busRdData,
	output isaPkg::word_t        busAddr,
	output isaPkg::word_t        busWrData,
	output logic                 busWrite,
	output logic                 busRead
);
	import isaPkg::*;
	import aluPkg::*;

	logic [addrWidth-1:0] fetchAddr0;
	logic [addrWidth-1:0] fetchAddr1;
	logic [addrWidth-1:0] fetchAddr2;
	logic [addrWidth-1:0] dataAddr;
	logic [addrWidth-1:0] wrAddr;
	word_t                fetchWord0;
	word_t                fetchWord1;
	word_t                fetchWord2;
	word_t                dataWord;
	word_t                memWrData;
	logic                 memWrEn;
	regSel_t              rdSelA;
	regSel_t              rdSelB;
	regSel_t              regWrSel;
	logic                 regWrEn;
	word_t                regWrData;
	word_t                rdDataA;
	word_t                rdDataB;
	logic                 aluStart;
	aluOp_t               aluOp;
	word_t                aluA;
	word_t                aluB;
	word_t                aluResult;
	flags_t               aluFlags;
	logic                 carry;

	progRam #(.addrWidth(addrWidth)) i_progRam (
		.clk(clk), .rstN(rstN),
		.fetchAddr0(fetchAddr0), .fetchAddr1(fetchAddr1), .fetchAddr2(fetchAddr2),
		.dataAddr(dataAddr), .wrAddr(wrAddr), .wrData(memWrData), .wrEn(memWrEn),
		.loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.fetchWord0(fetchWord0), .fetchWord1(fetchWord1), .fetchWord2(fetchWord2),
		.dataWord(dataWord)
	);

	regFile i_regFile (
		.clk(clk), .rstN(rstN),
		.rdSelA(rdSelA), .rdSelB(rdSelB),
		.wrSel(regWrSel), .wrEn(regWrEn), .wrData(regWrData),
		.rdDataA(rdDataA), .rdDataB(rdDataB),
		.regBx(busAddr), .regDx(busWrData) // bus follows bx and dx
	);

	alu i_alu (
		.clk(clk), .rstN(rstN), .start(aluStart), .op(aluOp),
		.a(aluA), .b(aluB), .carryIn(carry),
		.result(aluResult), .flagsOut(aluFlags)
	);

	cpuControl #(.addrWidth(addrWidth)) i_cpuControl (
		.clk(clk), .rstN(rstN),
		.fetchWord0(fetchWord0), .fetchWord1(fetchWord1), .fetchWord2(fetchWord2),
		.dataWord(dataWord), .rdDataA(rdDataA), .rdDataB(rdDataB), .regBx(busAddr),
		.aluResult(aluResult), .aluFlags(aluFlags), .busRdData(busRdData),
		.fetchAddr0(fetchAddr0), .fetchAddr1(fetchAddr1), .fetchAddr2(fetchAddr2),
		.dataAddr(dataAddr), .wrAddr(wrAddr), .wrData(memWrData), .wrEn(memWrEn),
		.rdSelA(rdSelA), .rdSelB(rdSelB), .regWrSel(regWrSel),
		.regWrEn(regWrEn), .regWrData(regWrData),
		.aluStart(aluStart), .aluOp(aluOp), .aluA(aluA), .aluB(aluB), .carryOut(carry),
		.busWrite(busWrite), .busRead(busRead)
	);

endmodule

// File: dv/cpuChecker.sv
module cpuChecker #(
	parameter int addrWidth = 12
) (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 loadEn,
	input  logic [addrWidth-1:0] loadAddr,
	input  isaPkg::word_t        loadData,
	input  isaPkg::word_t        busAddr,
	input  isaPkg::word_t        busWrData,
	input  logic                 busWrite,
	input  logic                 busRead,
	output int                   testsDone,
	output int                   errors
);
	timeunit 1ns;
	timeprecision 100ps;

	import isaPkg::*;
	import aluPkg::*;

	word_t mem [2 ** addrWidth]; // image of the loaded program
	word_t expAddr[$];
	word_t expData[$];
	bit    expLast[$];
	word_t expRdAddr[$];
	bit    rstSeen;
	bit    halted;
	int    testIdx;
	int    checked;

	function automatic int lenOf(word_t op);
		if (op == opMovi || op == opStore || op == opLoad) return 3;
		if (op inside {opMov, opAdd, opAdc, opSub, opSuc, opMul8, opCmp, opAnd, opNeg, opOr,
				opShl, opShr, opXor, opJmp, opJc, opJnc, opJz, opJnz}) return 2;
		return 1;
	endfunction

	// instruction-level model filling the expected OUT and IN queues
	task automatic runModel(output bit reachedEnd);
		word_t                r[4];
		flags_t               f;
		logic [addrWidth-1:0] pc;
		word_t                op;
		word_t                p1;
		word_t                p2;
		word_t                a;
		word_t                b;
		word_t                res;
		logic [16:0]          t;
		logic                 take;
		r = '{default: '0};
		f = '0;
		pc = '0;
		reachedEnd = 1'b0;
		for (int step = 0; step < 10000 && !reachedEnd; step++) begin
			op = mem[pc];
			p1 = mem[pc + 1'b1];
			p2 = mem[pc + 2'd2];
			a = r[p1[3:2]];
			b = r[p1[1:0]];
			take = 1'b0;
			case (op)
				opMov: r[p1[3:2]] = b;
				opMovi: r[p1[3:2]] = p2;
				opStore: mem[p2[addrWidth-1:0]] = b;
				opLoad: r[p1[3:2]] = mem[p2[addrWidth-1:0]];
				opIn: begin
					expRdAddr.push_back(r[1]);
					r[3] = ~(r[1] ^ 16'h5A5A);
				end
				opOut: begin
					expAddr.push_back(r[1]);
					expData.push_back(r[3]);
					reachedEnd = r[1] == haltAddr && p1 == opJmp
						&& p2[addrWidth-1:0] == pc + 1'b1;
					expLast.push_back(reachedEnd);
				end
				opAdd, opAdc: begin
					t = {1'b0, a} + {1'b0, b} + {16'h0, op == opAdc && f.carry};
					res = t[15:0];
					f = '{carry: t[16], zero: res == 0,
						overflow: a[15] == b[15] && res[15] != a[15]};
					r[p1[3:2]] = res;
				end
				opSub, opSuc, opCmp: begin
					t = {1'b0, a} - {1'b0, b} - {16'h0, op == opSuc && f.carry};
					res = t[15:0];
					f = '{carry: t[16], zero: res == 0,
						overflow: a[15] != b[15] && res[15] != a[15]};
					if (op != opCmp) r[p1[3:2]] = res;
				end
				opMul8, opAnd, opNeg, opOr, opXor, opShl, opShr: begin
					case (op)
						opMul8: res = word_t'(a[7:0]) * word_t'(b[7:0]);
						opAnd: res = a & b;
						opNeg: res = ~a;
						opOr: res = a | b;
						opXor: res = a ^ b;
						opShl: res = a << 1;
						default: res = a >> 1;
					endcase
					f.zero = res == 0; // carry and overflow kept
					r[p1[3:2]] = res;
				end
				opJmp: take = 1'b1;
				opJc: take = f.carry;
				opJnc: take = !f.carry;
				opJz: take = f.zero;
				opJnz: take = !f.zero;
				default: ;
			endcase
			pc = take ? p1[addrWidth-1:0] : pc + addrWidth'(lenOf(op));
		end
	endtask

	initial begin
		testsDone = 0;
		errors = 0;
		rstSeen = 1'b0;
		testIdx = 0;
		checked = 0;
	end

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		if (loadEn) mem[loadAddr] = loadData;
		if (rstN && !rstSeen) begin
			testIdx++;
			expAddr.delete();
			expData.delete();
			expLast.delete();
			expRdAddr.delete();
			runModel(halted);
			if (!halted) begin
				errors++;
				$display("model of test %0d ran off without reaching its end marker", testIdx);
			end
		end
		rstSeen = rstN;
		if (busRead && busWrite) begin
			errors++;
			$display("busRead and busWrite were high together at %0t", $time);
		end
		if (!rstN && (busRead || busWrite)) begin
			errors++;
			$display("bus strobe active during reset at %0t", $time);
		end
		if (rstN && busRead) begin
			if (expRdAddr.size() == 0) begin
				errors++;
				$display("unexpected IN read from %h at %0t", busAddr, $time);
			end else begin
				if (busAddr != expRdAddr[0]) begin
					errors++;
					$display("ERROR at %0t: IN of test %0d read from %h, expected %h",
						$time, testIdx, busAddr, expRdAddr[0]);
				end
				void'(expRdAddr.pop_front());
			end
		end
		if (rstN && busWrite) begin
			if (expAddr.size() == 0) begin
				errors++;
				$display("unexpected OUT of %h to %h at %0t", busWrData, busAddr, $time);
			end else begin
				checked++;
				if (busAddr != expAddr[0] || busWrData != expData[0]) begin
					errors++;
					$display("ERROR at %0t: OUT %0d of test %0d wrote %h to %h, expected %h to %h",
						$time, checked, testIdx, busWrData, busAddr, expData[0], expAddr[0]);
				end
				if (expLast[0]) begin
					if (expRdAddr.size() != 0) begin
						errors++;
						$display("test %0d ended with %0d IN reads that never happened",
							testIdx, expRdAddr.size());
					end
					testsDone++;
					$display("test %0d finished: %0d OUT writes checked, %0d errors so far",
						testIdx, checked, errors);
					checked = 0;
				end
				void'(expAddr.pop_front());
				void'(expData.pop_front());
				void'(expLast.pop_front());
			end
		end
	end

endmodule

// File: dv/cpuTb.sv
module cpuTb;
	timeunit 1ns;
	timeprecision 100ps;

	import isaPkg::*;

	localparam int addrWidth = 12;
	localparam int dataBase = 'h800; // data area sits well above the code
	localparam int dataSize = 256;
	localparam int maxCycles = 2000;

	logic                 clk;
	logic                 rstN;
	logic                 loadEn;
	logic [addrWidth-1:0] loadAddr;
	word_t                loadData;
	word_t                busRdData;
	word_t                busAddr;
	word_t                busWrData;
	logic                 busWrite;
	logic                 busRead;
	int                   testsDone;
	int                   errors;
	bit                   hung;

	word_t progOp[$];
	word_t progP1[$];
	word_t progP2[$];
	word_t image[$];

	cpuTop #(.addrWidth(addrWidth)) i_cpuTop (
		.clk(clk), .rstN(rstN), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.busRdData(busRdData), .busAddr(busAddr), .busWrData(busWrData),
		.busWrite(busWrite), .busRead(busRead)
	);

	cpuChecker #(.addrWidth(addrWidth)) i_cpuChecker (
		.clk(clk), .rstN(rstN), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.busAddr(busAddr), .busWrData(busWrData), .busWrite(busWrite), .busRead(busRead),
		.testsDone(testsDone), .errors(errors)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// the responder answers from bx a cycle later
	always @(posedge clk) begin
		#10;
		busRdData = ~(busAddr ^ 16'h5A5A);
	end

	function automatic int insnWords(word_t op);
		if (op == opMovi || op == opStore || op == opLoad) return 3;
		if (op inside {opMov, opAdd, opAdc, opSub, opSuc, opMul8, opCmp, opAnd, opNeg, opOr,
				opShl, opShr, opXor, opJmp, opJc, opJnc, opJz, opJnz}) return 2;
		return 1;
	endfunction

	function automatic word_t pickOp(int kind);
		word_t pool[$];
		case (kind)
			1: pool = '{opMovi, opMov, opStore, opLoad, opOut};
			2: pool = '{opMovi, opAdd, opAdc, opSub, opSuc, opCmp, opJc, opJnc, opJz, opJnz, opOut};
			3: pool = '{opMovi, opMul8, opAnd, opNeg, opOr, opXor, opShl, opShr, opOut};
			4: pool = '{opMovi, opCmp, opSub, opJc, opJnc, opJz, opJnz, opJmp, opOut};
			5: pool = '{opMovi, opIn, opOut, opMov};
			default: pool = '{opNop, opMov, opMovi, opStore, opLoad, opOut, opIn, opAdd, opAdc,
				opSub, opSuc, opMul8, opCmp, opAnd, opNeg, opOr, opXor, opShl, opShr, opJmp,
				opJc, opJnc, opJz, opJnz, 16'h003F}; // 3F is not an opcode
		endcase
		return pool[$urandom % pool.size()];
	endfunction

	function automatic word_t fillWord(int a);
		return word_t'((a * 40503) ^ (a >> 3) ^ 'h3C5A);
	endfunction

	task automatic buildProgram(int kind, int count);
		int addr[$];
		int jumps[$];
		int pc;
		int j;
		word_t op;
		word_t p2;
		progOp.delete();
		progP1.delete();
		progP2.delete();
		image.delete();
		for (int i = 0; i < count; i++) begin
			op = pickOp(kind);
			p2 = '0;
			if (op == opMovi) p2 = ($urandom % 4 == 0) ? word_t'($urandom % 3) : word_t'($urandom);
			if (op == opStore || op == opLoad) p2 = word_t'(dataBase + $urandom % dataSize);
			if (op inside {opJmp, opJc, opJnc, opJz, opJnz}) jumps.push_back(i);
			progOp.push_back(op);
			progP1.push_back(word_t'($urandom % 16)); // dst and src fields
			progP2.push_back(p2);
		end
		// end marker is bx <= FFFF, an OUT and a jump to self
		progOp.push_back(opMovi);
		progP1.push_back(16'h0004);
		progP2.push_back(haltAddr);
		progOp.push_back(opOut);
		progP1.push_back('0);
		progP2.push_back('0);
		progOp.push_back(opJmp);
		progP1.push_back('0);
		progP2.push_back('0);
		pc = 0;
		foreach (progOp[i]) begin
			addr.push_back(pc);
			pc += insnWords(progOp[i]);
		end
		foreach (jumps[k]) begin
			j = jumps[k] + 1 + int'($urandom % (count - jumps[k])); // forward only
			progP1[jumps[k]] = word_t'(addr[j]);
		end
		progP1[count + 2] = word_t'(addr[count + 2]);
		foreach (progOp[i]) begin
			image.push_back(progOp[i]);
			if (insnWords(progOp[i]) > 1) image.push_back(progP1[i]);
			if (insnWords(progOp[i]) > 2) image.push_back(progP2[i]);
		end
	endtask

	task automatic loadProgram();
		for (int i = 0; i < image.size() + dataSize; i++) begin
			@(posedge clk);
			#10;
			loadEn = 1'b1;
			if (i < image.size()) begin
				loadAddr = addrWidth'(i);
				loadData = image[i];
			end else begin
				loadAddr = addrWidth'(dataBase + i - image.size());
				loadData = fillWord(dataBase + i - image.size());
			end
		end
		@(posedge clk);
		#10;
		loadEn = 1'b0;
	endtask

	task automatic runTest(int kind, int count, output bit timedOut);
		int startCount;
		int cycles;
		@(posedge clk);
		#10;
		rstN = 1'b0;
		buildProgram(kind, count);
		loadProgram();
		@(posedge clk);
		#10;
		rstN = 1'b1;
		startCount = testsDone;
		cycles = 0;
		while (testsDone == startCount && cycles < maxCycles) begin
			@(posedge clk);
			cycles++;
		end
		timedOut = (testsDone == startCount);
		if (timedOut) begin
			$display("timeout: test %0d never reached its end marker", kind);
		end
	endtask

	initial begin
		void'($urandom(32'he8f6));
		rstN = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		busRdData = '0;
		hung = 1'b0;
		repeat (4) @(posedge clk);
		runTest(1, 20, hung); // move, store and load round trip
		if (!hung) runTest(2, 30, hung); // add, sub and flags
		if (!hung) runTest(3, 30, hung); // mul8 and bitwise
		if (!hung) runTest(4, 30, hung); // jumps
		if (!hung) runTest(5, 20, hung); // IN responder
		if (!hung) runTest(6, 40, hung); // fully mixed
		repeat (2) @(posedge clk);
		$display("tests run %0d, errors %0d", testsDone, errors);
		if (!hung && errors == 0 && testsDone == 6) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: files.f
hdl/isaPkg.sv
hdl/aluPkg.sv
hdl/progRam.sv
hdl/regFile.sv
hdl/alu.sv
hdl/cpuControl.sv
hdl/cpuTop.sv
dv/cpuChecker.sv
dv/cpuTb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = cpuTb
FILELIST  = files.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation gave no result"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
